// ==== hw/router_egress_config.svh ====
//////////////////////////////
// Sizing and timing macros for the router egress path
// Include wherever ports, queues or latencies are needed
//////////////////////////////

`ifndef ROUTER_EGRESS_CONFIG_SVH
`define ROUTER_EGRESS_CONFIG_SVH

// Output ports
`define ROUTER_NUM_EGR_PORTS   4
// Priority queues per port, highest index wins
`define ROUTER_QUEUES_PER_PORT 4
// Cycles from dequeue request to notification
`define ROUTER_DQ_LATENCY      3
// Packet entries per queue
`define ROUTER_PKT_FIFO_DEPTH  4
// Longest packet in words
`define ROUTER_MAX_PKT_WORDS   8
// Egress buffer words per port
`define ROUTER_EGR_BUF_DEPTH   8

`endif

// ==== hw/router_egress_pkg.sv ====
//////////////////////////////
// Shared types for the router egress blocks
//////////////////////////////

`default_nettype none

package router_egress_pkg;

    // Output port number
    typedef logic [1:0] port_id_t;

    // Priority level inside a port
    typedef logic [1:0] prio_t;

    // Split view of a queue reference, port in the upper bits
    typedef struct packed {
        port_id_t port;
        prio_t    prio;
    } queue_addr_t;

    // One queue reference, read either flat or as port/prio
    // Flat form indexes the empty vector and the FIFO arrays
    typedef union packed {
        logic [3:0]  flat;
        queue_addr_t addr;
    } queue_ref_u;

    // Packet length in words
    typedef logic [3:0] pkt_len_t;

endpackage

`default_nettype wire

// ==== hw/dequeue_if.sv ====
//////////////////////////////
// Dequeue request and notification link
// Scheduler drives requests, queue store answers with notifications
//////////////////////////////

`timescale 1ns/1ns
`default_nettype none

interface dequeue_if;

    // Request strobe and target queue
    logic                          req_valid;
    router_egress_pkg::queue_ref_u req_queue;

    // Notification word, last is only meaningful with valid
    logic                          notif_valid;
    logic                          notif_last;
    router_egress_pkg::queue_ref_u notif_queue;

    modport sched (
        output req_valid,
        output req_queue,
        input  notif_valid,
        input  notif_last,
        input  notif_queue
    );

    modport store (
        input  req_valid,
        input  req_queue,
        output notif_valid,
        output notif_last,
        output notif_queue
    );

endinterface

`default_nettype wire

// ==== hw/egress_scheduler.sv ====
//////////////////////////////
// Egress scheduler, round robin over ports, strict priority inside
// a port, sticky on one queue until its packet's last word
//////////////////////////////

`timescale 1ns/1ns
`default_nettype none

`include "router_egress_config.svh"

module egress_scheduler (
    input  logic dequeue_notification,
    input  logic rst_n,
    input  logic [`ROUTER_NUM_EGR_PORTS*`ROUTER_QUEUES_PER_PORT-1:0] queue_empty,
    input  logic [`ROUTER_NUM_EGR_PORTS-1:0] egr_buf_ready,
    dequeue_if.sched dq
);

    localparam int NP  = `ROUTER_NUM_EGR_PORTS;
    localparam int QPP = `ROUTER_QUEUES_PER_PORT;
    localparam int LAT = `ROUTER_DQ_LATENCY;

    //////////////////////////////
    // State
    //////////////////////////////

    // Last granted port, also the search start
    router_egress_pkg::port_id_t sel_port;
    logic                        sel_valid;

    // One shift register per port, nonzero while a request is in flight
    logic [LAT:0]                in_flight [NP];

    // Sticky queue per port
    logic [NP-1:0]               pkt_in_progress;
    router_egress_pkg::prio_t    active_queue [NP];

    // Search results
    logic [NP-1:0]               port_eligible;
    logic                        pick_found;
    router_egress_pkg::port_id_t pick_port;

    // Priority pick inside the selected port
    logic [QPP-1:0]              sel_empty;
    logic                        sel_any;
    router_egress_pkg::prio_t    hi_prio;

    //////////////////////////////
    // Port choice
    //////////////////////////////

    // Eligible: some queue pending, nothing in flight, buffer room
    always_comb begin
        for (int p = 0; p < NP; p++) begin
            port_eligible[p] = ~&queue_empty[p*QPP +: QPP] && ~|in_flight[p] && egr_buf_ready[p];
        end
    end

    // First eligible port from the pointer onwards
    // The pointer port itself is usually still blocked by its in-flight request
    always_comb begin
        int cand;
        pick_found = 1'b0;
        pick_port  = sel_port;
        for (int i = 0; i < NP; i++) begin
            cand = (int'(sel_port) + i) % NP;
            if (!pick_found && port_eligible[cand]) begin
                pick_found = 1'b1;
                pick_port  = router_egress_pkg::port_id_t'(cand);
            end
        end
    end

    //////////////////////////////
    // Queue choice
    //////////////////////////////

    // Highest non-empty prio of the selected port, ascending scan so top wins
    always_comb begin
        sel_empty = queue_empty[sel_port*QPP +: QPP];
        sel_any   = ~&sel_empty;
        hi_prio   = '0;
        for (int k = 0; k < QPP; k++) begin
            if (!sel_empty[k]) begin
                hi_prio = router_egress_pkg::prio_t'(k);
            end
        end
    end

    always_ff @(posedge dequeue_notification or negedge rst_n) begin
        if (!rst_n) begin
            sel_port        <= '0;
            sel_valid       <= 1'b0;
            in_flight       <= '{default: '0};
            pkt_in_progress <= '0;
            active_queue    <= '{default: '0};
            dq.req_valid    <= 1'b0;
            dq.req_queue    <= '0;
        end else begin
            // Age in-flight markers
            for (int p = 0; p < NP; p++) begin
                in_flight[p] <= {in_flight[p][LAT-1:0], 1'b0};
            end

            // Selection, request follows one cycle later
            sel_valid <= pick_found;
            if (pick_found) begin
                sel_port               <= pick_port;
                in_flight[pick_port][0] <= 1'b1;
            end

            // Queue may have drained since selection, then no request
            dq.req_valid          <= sel_valid && sel_any;
            dq.req_queue.addr.port <= sel_port;
            if (pkt_in_progress[sel_port]) begin
                dq.req_queue.addr.prio <= active_queue[sel_port];
            end else begin
                dq.req_queue.addr.prio <= hi_prio;
                if (sel_valid && sel_any) begin
                    active_queue[sel_port]    <= hi_prio;
                    pkt_in_progress[sel_port] <= 1'b1;
                end
            end

            // Last word releases the port's sticky queue
            if (dq.notif_valid && dq.notif_last) begin
                pkt_in_progress[dq.notif_queue.addr.port] <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/packet_queue_store.sv ====
//////////////////////////////
// Packet length FIFOs per queue with fixed-latency word dequeue
// Answers each dequeue request with one notification word
//////////////////////////////

`timescale 1ns/1ns
`default_nettype none

`include "router_egress_config.svh"

module packet_queue_store (
    input  logic dequeue_notification,
    input  logic rst_n,
    input  logic enq_valid,
    input  router_egress_pkg::queue_ref_u enq_queue,
    input  router_egress_pkg::pkt_len_t   enq_len,
    output logic [`ROUTER_NUM_EGR_PORTS*`ROUTER_QUEUES_PER_PORT-1:0] enq_ready,
    output logic [`ROUTER_NUM_EGR_PORTS*`ROUTER_QUEUES_PER_PORT-1:0] queue_empty,
    dequeue_if.store dq
);

    localparam int NQ    = `ROUTER_NUM_EGR_PORTS * `ROUTER_QUEUES_PER_PORT;
    localparam int DEPTH = `ROUTER_PKT_FIFO_DEPTH;
    localparam int LAT   = `ROUTER_DQ_LATENCY;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    // One circular length list per queue
    router_egress_pkg::pkt_len_t   fifo_mem [NQ][DEPTH];
    logic [PTR_W-1:0]              wr_ptr [NQ];
    logic [PTR_W-1:0]              rd_ptr [NQ];
    logic [CNT_W-1:0]              pkt_count [NQ];

    // Words already sent of each head packet
    router_egress_pkg::pkt_len_t   word_cnt [NQ];

    // Request delay line
    logic [LAT-1:0]                pipe_valid;
    router_egress_pkg::queue_ref_u pipe_queue [LAT];

    // Head of the queue at the end of the delay line
    logic [3:0]                    out_q;
    router_egress_pkg::pkt_len_t   head_len;

    logic                          enq_fire;
    logic [NQ-1:0]                 enq_hit;
    logic [NQ-1:0]                 pop_hit;
    logic [NQ-1:0]                 word_hit;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        return (int'(ptr) == DEPTH - 1) ? '0 : ptr + 1'b1;
    endfunction

    //////////////////////////////
    // Flags and notification
    //////////////////////////////

    always_comb begin
        for (int q = 0; q < NQ; q++) begin
            enq_ready[q]   = pkt_count[q] < DEPTH;
            queue_empty[q] = pkt_count[q] == 0;
        end
    end

    assign out_q    = pipe_queue[LAT-1].flat;
    assign head_len = fifo_mem[out_q][rd_ptr[out_q]];

    assign dq.notif_valid = pipe_valid[LAT-1];
    assign dq.notif_queue = pipe_queue[LAT-1];
    assign dq.notif_last  = word_cnt[out_q] == head_len - router_egress_pkg::pkt_len_t'(1);

    // Full queue drops the enqueue
    assign enq_fire = enq_valid && enq_ready[enq_queue.flat];

    always_comb begin
        for (int q = 0; q < NQ; q++) begin
            enq_hit[q]  = enq_fire && enq_queue.flat == q;
            word_hit[q] = dq.notif_valid && out_q == q;
            pop_hit[q]  = word_hit[q] && dq.notif_last;
        end
    end

    //////////////////////////////
    // Storage and pointers
    //////////////////////////////

    always_ff @(posedge dequeue_notification) begin
        if (enq_fire) begin
            fifo_mem[enq_queue.flat][wr_ptr[enq_queue.flat]] <= enq_len;
        end
    end

    always_ff @(posedge dequeue_notification or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr    <= '{default: '0};
            rd_ptr    <= '{default: '0};
            pkt_count <= '{default: '0};
            word_cnt  <= '{default: '0};
        end else begin
            for (int q = 0; q < NQ; q++) begin
                if (enq_hit[q]) begin
                    wr_ptr[q] <= next_ptr(wr_ptr[q]);
                end
                // Count head words and pop the entry after the last
                if (pop_hit[q]) begin
                    rd_ptr[q]   <= next_ptr(rd_ptr[q]);
                    word_cnt[q] <= '0;
                end else if (word_hit[q]) begin
                    word_cnt[q] <= word_cnt[q] + 1'b1;
                end
                case ({enq_hit[q], pop_hit[q]})
                    2'b10:   pkt_count[q] <= pkt_count[q] + 1'b1;
                    2'b01:   pkt_count[q] <= pkt_count[q] - 1'b1;
                    default: pkt_count[q] <= pkt_count[q];
                endcase
            end
        end
    end

    //////////////////////////////
    // Latency pipeline
    //////////////////////////////

    always_ff @(posedge dequeue_notification or negedge rst_n) begin
        if (!rst_n) begin
            pipe_valid <= '0;
        end else begin
            pipe_valid <= {pipe_valid[LAT-2:0], dq.req_valid};
        end
    end

    // Queue tags travel beside the valid bits
    always_ff @(posedge dequeue_notification) begin
        pipe_queue[0] <= dq.req_queue;
        for (int s = 1; s < LAT; s++) begin
            pipe_queue[s] <= pipe_queue[s-1];
        end
    end

endmodule

`default_nettype wire

// ==== hw/egress_port_buffer.sv ====
//////////////////////////////
// Egress buffer occupancy per port
// Counts notified words in, pops out, and flags room
//////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module egress_port_buffer #(
    parameter int NUM_PORTS  = 4,
    parameter int BUF_DEPTH  = 8,
    parameter int DQ_LATENCY = 3,
    parameter int LEVEL_W    = $clog2(BUF_DEPTH + 1)
) (
    input  logic                          dequeue_notification,
    input  logic                          rst_n,
    input  logic                          notif_valid,
    input  router_egress_pkg::queue_ref_u notif_queue,
    input  logic [NUM_PORTS-1:0]          egr_pop,
    output logic [NUM_PORTS-1:0]          egr_buf_ready,
    output logic [LEVEL_W-1:0]            egr_level [NUM_PORTS]
);

    // Room for words already in flight plus one more request
    localparam int READY_MAX = BUF_DEPTH - DQ_LATENCY - 2;

    logic [NUM_PORTS-1:0] word_in;
    logic [NUM_PORTS-1:0] word_out;

    //////////////////////////////
    // Per-port events
    //////////////////////////////

    always_comb begin
        for (int p = 0; p < NUM_PORTS; p++) begin
            word_in[p]  = notif_valid && int'(notif_queue.addr.port) == p;
            // Pop on an empty buffer is ignored
            word_out[p] = egr_pop[p] && egr_level[p] != '0;
        end
    end

    always_ff @(posedge dequeue_notification or negedge rst_n) begin
        if (!rst_n) begin
            egr_level <= '{default: '0};
        end else begin
            for (int p = 0; p < NUM_PORTS; p++) begin
                case ({word_in[p], word_out[p]})
                    2'b10:   egr_level[p] <= egr_level[p] + 1'b1;
                    2'b01:   egr_level[p] <= egr_level[p] - 1'b1;
                    // Word in and out together, level holds
                    default: egr_level[p] <= egr_level[p];
                endcase
            end
        end
    end

    // Ready level straight from the count
    always_comb begin
        for (int p = 0; p < NUM_PORTS; p++) begin
            egr_buf_ready[p] = int'(egr_level[p]) <= READY_MAX;
        end
    end

endmodule

`default_nettype wire

// ==== hw/router_egress_top.sv ====
//////////////////////////////
// Router egress top level wiring the queue store, scheduler and port buffers
//////////////////////////////

`timescale 1ns/1ns
`default_nettype none

`include "router_egress_config.svh"

module router_egress_top (
    input  logic                          dequeue_notification,
    input  logic                          rst_n,
    input  logic                          enq_valid,
    input  router_egress_pkg::queue_ref_u enq_queue,
    input  router_egress_pkg::pkt_len_t   enq_len,
    output logic [`ROUTER_NUM_EGR_PORTS*`ROUTER_QUEUES_PER_PORT-1:0] enq_ready,
    output logic [`ROUTER_NUM_EGR_PORTS*`ROUTER_QUEUES_PER_PORT-1:0] queue_empty,
    input  logic [`ROUTER_NUM_EGR_PORTS-1:0] egr_pop,
    output logic [`ROUTER_NUM_EGR_PORTS-1:0] egr_buf_ready,
    output logic                          egr_word_valid,
    output router_egress_pkg::queue_ref_u egr_word_queue,
    output logic                          egr_word_last
);

    localparam int LEVEL_W = $clog2(`ROUTER_EGR_BUF_DEPTH + 1);

    dequeue_if dq ();

    // Notification taps
    logic                          notif_valid;
    logic                          notif_last;
    router_egress_pkg::queue_ref_u notif_queue;

    assign notif_valid = dq.notif_valid;
    assign notif_last  = dq.notif_last;
    assign notif_queue = dq.notif_queue;

    egress_scheduler u_sched (
        .dequeue_notification (dequeue_notification),
        .rst_n                (rst_n),
        .queue_empty          (queue_empty),
        .egr_buf_ready        (egr_buf_ready),
        .dq                   (dq.sched)
    );

    packet_queue_store u_store (
        .dequeue_notification (dequeue_notification),
        .rst_n                (rst_n),
        .enq_valid            (enq_valid),
        .enq_queue            (enq_queue),
        .enq_len              (enq_len),
        .enq_ready            (enq_ready),
        .queue_empty          (queue_empty),
        .dq                   (dq.store)
    );

    egress_port_buffer #(
        .NUM_PORTS  (`ROUTER_NUM_EGR_PORTS),
        .BUF_DEPTH  (`ROUTER_EGR_BUF_DEPTH),
        .DQ_LATENCY (`ROUTER_DQ_LATENCY),
        .LEVEL_W    (LEVEL_W)
    ) u_buf (
        .dequeue_notification (dequeue_notification),
        .rst_n                (rst_n),
        .notif_valid          (notif_valid),
        .notif_queue          (notif_queue),
        .egr_pop              (egr_pop),
        .egr_buf_ready        (egr_buf_ready),
        .egr_level            ()
    );

    // Egress words are the notifications themselves
    assign egr_word_valid = notif_valid;
    assign egr_word_queue = notif_queue;
    assign egr_word_last  = notif_last;

endmodule

`default_nettype wire

// ==== tests/router_egress_assertions.sv ====
//////////////////////////////
// Timing checks bound into the port buffer and the scheduler
//////////////////////////////

`timescale 1ns/1ns
`default_nettype none

`include "router_egress_config.svh"

module router_egress_assertions #(
    parameter int MIN_GAP   = 4,
    parameter int READY_LAG = 2
) (
    input logic                              clk,
    input logic                              rst_n,
    input logic                              ev_valid,
    input router_egress_pkg::port_id_t       ev_port,
    input logic [`ROUTER_NUM_EGR_PORTS-1:0]  buf_ready
);

    localparam int NP = `ROUTER_NUM_EGR_PORTS;

    // Failed assertions so far
    int fail_count = 0;

    for (genvar p = 0; p < NP; p++) begin : g_port
        logic hit;
        assign hit = ev_valid && ev_port == p;

        // Same port stays quiet for the rest of the gap
        port_spacing: assert property (@(posedge clk) disable iff (!rst_n)
            hit |=> !hit [*MIN_GAP-1])
            else begin
                $error("port %0d events closer than %0d cycles", p, MIN_GAP);
                fail_count++;
            end

        // Port had buffer room when it was selected
        ready_at_select: assert property (@(posedge clk) disable iff (!rst_n)
            hit |-> $past(buf_ready[p], READY_LAG))
            else begin
                $error("port %0d served without buffer room", p);
                fail_count++;
            end
    end

endmodule

// Words reach the buffer five cycles after selection
bind egress_port_buffer router_egress_assertions #(
    .MIN_GAP   (`ROUTER_DQ_LATENCY + 1),
    .READY_LAG (`ROUTER_DQ_LATENCY + 2)
) u_word_checks (
    .clk       (dequeue_notification),
    .rst_n     (rst_n),
    .ev_valid  (notif_valid),
    .ev_port   (notif_queue.addr.port),
    .buf_ready (egr_buf_ready)
);

// Requests leave two cycles after selection
bind egress_scheduler router_egress_assertions #(
    .MIN_GAP   (`ROUTER_DQ_LATENCY + 1),
    .READY_LAG (2)
) u_req_checks (
    .clk       (dequeue_notification),
    .rst_n     (rst_n),
    .ev_valid  (dq.req_valid),
    .ev_port   (dq.req_queue.addr.port),
    .buf_ready (egr_buf_ready)
);

`default_nettype wire

// ==== tests/router_egress_tb.sv ====
//////////////////////////////
// Testbench for the router egress top with random enqueue and drain
// checked against a cycle-level model of queues, words and buffer levels
//////////////////////////////

`timescale 1ns/1ns
`default_nettype none

`include "router_egress_config.svh"

module router_egress_tb;

    localparam int NP    = `ROUTER_NUM_EGR_PORTS;
    localparam int QPP   = `ROUTER_QUEUES_PER_PORT;
    localparam int NQ    = NP * QPP;
    localparam int LAT   = `ROUTER_DQ_LATENCY;
    localparam int DEPTH = `ROUTER_PKT_FIFO_DEPTH;
    localparam int BUF   = `ROUTER_EGR_BUF_DEPTH;
    localparam int DRAIN_LIMIT = 3000;

    logic                          dequeue_notification;
    logic                          rst_n;
    logic                          enq_valid;
    router_egress_pkg::queue_ref_u enq_queue;
    router_egress_pkg::pkt_len_t   enq_len;
    logic [NQ-1:0]                 enq_ready;
    logic [NQ-1:0]                 queue_empty;
    logic [NP-1:0]                 egr_pop;
    logic [NP-1:0]                 egr_buf_ready;
    logic                          egr_word_valid;
    router_egress_pkg::queue_ref_u egr_word_queue;
    logic                          egr_word_last;

    //////////////////////////////
    // Reference model
    //////////////////////////////

    // Pending packet lengths in a circular list per queue
    int            pend_len [NQ][DEPTH];
    int            pend_head [NQ];
    int            pend_cnt [NQ];
    // Words already seen of each head packet
    int            word_cnt [NQ];
    int            level [NP];
    int            last_word_cyc [NP];
    // Queue with an open packet per port or -1
    int            open_q [NP];
    // Which queues held packets at each stamped cycle
    logic [NQ-1:0] hist_busy [16];
    int            hist_stamp [16];
    int            cyc;
    int            value_errors;
    int            timeouts;
    int            assert_fails;

    router_egress_top dut (.*);

    initial dequeue_notification = 1'b0;
    always #20 dequeue_notification = ~dequeue_notification;

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            value_errors++;
            $display("FAILED at %0t ns: %s, got %0d, expected %0d", $time, what, actual, expected);
        end
    endtask

    function automatic bit port_idle(input int p);
        int sum;
        sum = level[p];
        for (int k = 0; k < QPP; k++) begin
            sum += pend_cnt[p*QPP + k];
        end
        return sum == 0;
    endfunction

    // Check one egress word against the model and advance it
    task automatic check_word();
        router_egress_pkg::queue_ref_u wq;
        int q;
        int p;
        int slot;
        bit exp_last;
        wq = egr_word_queue;
        q  = wq.flat;
        p  = wq.addr.port;
        if (pend_cnt[q] == 0) begin
            check_value(0, 1, $sformatf("word for queue %0d with nothing pending", q));
            return;
        end
        if (last_word_cyc[p] >= 0) begin
            check_value(cyc - last_word_cyc[p] >= LAT + 1, 1,
                        $sformatf("spacing of port %0d words", p));
        end
        last_word_cyc[p] = cyc;
        // No other queue of the port may cut into an open packet
        if (open_q[p] >= 0) begin
            check_value(q, open_q[p], $sformatf("queue of word inside open packet, port %0d", p));
        end
        // No higher priority pending when the first word's queue was chosen
        slot = (cyc - LAT - 1) % 16;
        if (word_cnt[q] == 0 && hist_stamp[slot] == cyc - LAT - 1) begin
            for (int h = int'(wq.addr.prio) + 1; h < QPP; h++) begin
                check_value(hist_busy[slot][p*QPP + h], 0,
                            $sformatf("queue %0d started while prio %0d of port %0d waited", q, h, p));
            end
        end
        exp_last = word_cnt[q] + 1 == pend_len[q][pend_head[q]];
        check_value(egr_word_last, exp_last, $sformatf("last flag of queue %0d", q));
        if (exp_last) begin
            pend_head[q] = (pend_head[q] + 1) % DEPTH;
            pend_cnt[q]--;
            word_cnt[q] = 0;
            open_q[p]   = -1;
        end else begin
            word_cnt[q]++;
            open_q[p] = q;
        end
        level[p]++;
    endtask

    // One clock cycle of driving, sampling at the falling edge and model update
    task automatic run_cycle(input bit allow_enq, input int hold_port);
        int q;
        logic [NQ-1:0] busy_now;
        @(posedge dequeue_notification);
        cyc++;
        #2;
        enq_valid = 1'b0;
        q = $urandom % NQ;
        if (allow_enq && ($urandom % 3 != 0) && pend_cnt[q] < DEPTH) begin
            enq_valid      = 1'b1;
            enq_queue.flat = 4'(q);
            enq_len        = router_egress_pkg::pkt_len_t'($urandom_range(`ROUTER_MAX_PKT_WORDS, 1));
        end
        // Pop only words the model knows are buffered
        for (int p = 0; p < NP; p++) begin
            egr_pop[p] = p != hold_port && level[p] > 0 && $urandom % 2 == 0;
        end
        @(negedge dequeue_notification);
        for (int k = 0; k < NQ; k++) begin
            check_value(queue_empty[k], pend_cnt[k] == 0, $sformatf("queue_empty[%0d]", k));
            check_value(enq_ready[k], pend_cnt[k] < DEPTH, $sformatf("enq_ready[%0d]", k));
            busy_now[k] = pend_cnt[k] != 0;
        end
        for (int p = 0; p < NP; p++) begin
            check_value(egr_buf_ready[p], level[p] <= BUF - LAT - 2,
                        $sformatf("egr_buf_ready[%0d]", p));
            check_value(level[p] <= BUF, 1, $sformatf("level of port %0d within depth", p));
        end
        hist_busy[cyc % 16]  = busy_now;
        hist_stamp[cyc % 16] = cyc;
        if (egr_word_valid) begin
            check_word();
        end
        for (int p = 0; p < NP; p++) begin
            level[p] -= egr_pop[p];
        end
        if (enq_valid) begin
            q = enq_queue.flat;
            pend_len[q][(pend_head[q] + pend_cnt[q]) % DEPTH] = enq_len;
            pend_cnt[q]++;
        end
    endtask

    // Run without enqueues until the port has nothing left
    task automatic drain_port(input int p);
        int n;
        n = 0;
        while (!port_idle(p) && n < DRAIN_LIMIT) begin
            run_cycle(1'b0, -1);
            n++;
        end
        if (!port_idle(p)) begin
            timeouts++;
            $display("Timeout: port %0d still holds packets after %0d drain cycles", p, n);
        end
    endtask

    initial begin
        void'($urandom(32'h5a75));
        rst_n     = 1'b0;
        enq_valid = 1'b0;
        enq_queue = '0;
        enq_len   = '0;
        egr_pop   = '0;
        cyc = 0;
        value_errors = 0;
        timeouts = 0;
        assert_fails = 0;
        for (int k = 0; k < NQ; k++) begin
            pend_head[k] = 0;
            pend_cnt[k]  = 0;
            word_cnt[k]  = 0;
        end
        for (int p = 0; p < NP; p++) begin
            level[p] = 0;
            last_word_cyc[p] = -1;
            open_q[p] = -1;
        end
        for (int s = 0; s < 16; s++) begin
            hist_stamp[s] = -1;
        end
        repeat (8) @(posedge dequeue_notification);
        #2 rst_n = 1'b1;
        @(negedge dequeue_notification);
        check_value(egr_word_valid, 0, "egr_word_valid after reset");
        check_value(queue_empty, {NQ{1'b1}}, "queue_empty after reset");
        check_value(egr_buf_ready, {NP{1'b1}}, "egr_buf_ready after reset");

        // Free running traffic followed by back-pressure on each port in turn
        repeat (600) run_cycle(1'b1, -1);
        for (int p = 0; p < NP; p++) begin
            repeat (150) run_cycle(1'b1, p);
            drain_port(p);
        end
        for (int p = 0; p < NP; p++) begin
            drain_port(p);
        end

        // Bound checker failures count as errors too
        assert_fails = dut.u_buf.u_word_checks.fail_count
                     + dut.u_sched.u_req_checks.fail_count;
        $display("Run over after %0d cycles: %0d value errors, %0d timeouts, %0d assert errors",
                 cyc, value_errors, timeouts, assert_fails);
        if (value_errors == 0 && timeouts == 0 && assert_fails == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+hw
hw/router_egress_pkg.sv
hw/dequeue_if.sv
hw/egress_scheduler.sv
hw/packet_queue_store.sv
hw/egress_port_buffer.sv
hw/router_egress_top.sv
tests/router_egress_assertions.sv
tests/router_egress_tb.sv

// ==== Bender.yml ====
package:
  name: router_egress

sources:
  - include_dirs:
      - hw
    files:
      - hw/router_egress_pkg.sv
      - hw/dequeue_if.sv
      - hw/egress_scheduler.sv
      - hw/packet_queue_store.sv
      - hw/egress_port_buffer.sv
      - hw/router_egress_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - tests/router_egress_assertions.sv
      - tests/router_egress_tb.sv
